/* lsuOrder_params.svh */
`ifndef LSU_ORDER_PARAMS_SVH
`define LSU_ORDER_PARAMS_SVH

// Number of load buffer entries, must be a power of two
`define LB_SIZE 8

// Device window that is only ever accessed non-speculatively and in order
`define MMIO_BASE 32'hf000_0000
`define MMIO_END 32'hf0ff_ffff

`define IS_MMIO(addr) (((addr) >= `MMIO_BASE) && ((addr) <= `MMIO_END))

// Most committed loads that can leave the buffer head in one cycle
`define RETIRE_WIDTH 4

`endif

/* memOpPkg.sv */
package memOpPkg;

    // Instruction sequence number, compared by signed wrap-around difference
    typedef logic [6:0] SqN;

    // Load sequence number, the low bits select the load buffer slot
    typedef logic [5:0] LoadSqN;

    typedef logic [5:0] Tag;

    typedef enum logic [1:0] {
        SizeByte = 2'd0,
        SizeHalf = 2'd1,
        SizeWord = 2'd2
    } AccessSize;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        AccessSize   size;
        logic        signExtend;
        SqN          sqN;
        LoadSqN      loadSqN;
        Tag          tagDst;
        logic        doNotCommit;
    } AguLoad;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        AccessSize   size;
        logic [31:0] pc;
        logic        compressed;
        SqN          sqN;
        LoadSqN      loadSqN;
        logic        doNotCommit;
    } AguStore;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        AccessSize   size;
        logic        signExtend;
        SqN          sqN;
        LoadSqN      loadSqN;
        Tag          tagDst;
        logic        doNotCommit;
        logic        isMmio;
    } MemLoad;

    // Byte lanes touched within the aligned word, accesses are naturally aligned
    function automatic logic [3:0] byteMask(input logic [1:0] offset, input AccessSize size);
        logic [3:0] lanes;
        case (size)
            SizeByte: lanes = 4'b0001;
            SizeHalf: lanes = 4'b0011;
            default:  lanes = 4'b1111;
        endcase
        return lanes << offset;
    endfunction

    function automatic logic bytesOverlap(input logic [31:0] addrA, input AccessSize sizeA,
                                          input logic [31:0] addrB, input AccessSize sizeB);
        return (addrA[31:2] == addrB[31:2]) &&
               |(byteMask(addrA[1:0], sizeA) & byteMask(addrB[1:0], sizeB));
    endfunction

endpackage

/* recoveryPkg.sv */
package recoveryPkg;

    // Redirect request, used both for branch flushes coming into the LSU
    // and for ordering violations leaving it
    typedef struct packed {
        logic             taken;
        memOpPkg::SqN     sqN;
        memOpPkg::LoadSqN loadSqN;
        logic [31:0]      dstPc;
        logic             flush;
    } Recovery;

endpackage

/* lsuIfc.sv */
`timescale 1ns/10ps

// Late load handshake from the load buffer to the memory port arbiter.
// directValid qualifies the current AGU load when the buffer did not delay it
interface lateLoadIf;
    logic             valid;
    logic             accept;
    logic             directValid;
    memOpPkg::MemLoad load;

    modport source (
        output valid,
        output load,
        output directValid,
        input  accept
    );

    modport sink (
        input  valid,
        input  load,
        input  directValid,
        output accept
    );
endinterface

// Load acknowledge from the memory port, a failed ack makes the load reissue
interface ldAckIf;
    logic             valid;
    logic             fail;
    memOpPkg::LoadSqN loadSqN;

    modport source (output valid, output fail, output loadSqN);
    modport sink (input valid, input fail, input loadSqN);
endinterface

/* lateIssueSelect.sv */
`timescale 1ns/10ps
`include "lsuOrder_params.svh"

// entryValid marks entries that still wait to issue, and entryPending marks
// the subset of those that may issue speculatively
module lateIssueSelect (
    input  logic [`LB_SIZE-1:0]         entryValid,
    input  logic [`LB_SIZE-1:0]         entryPending,
    input  logic                        entryInOrderReady,
    input  logic [$clog2(`LB_SIZE)-1:0] deqIndex,
    output logic [$clog2(`LB_SIZE)-1:0] issueIdx,
    output logic                        issueValid
);

    localparam int IdxWidth = $clog2(`LB_SIZE);

    always_comb begin
        logic [IdxWidth-1:0] idx;
        issueIdx = deqIndex;
        issueValid = 1'b0;

        // Oldest speculative candidate first, counting from the buffer head
        for (int i = 0; i < `LB_SIZE; i++) begin
            idx = deqIndex + IdxWidth'(i);
            if (entryPending[idx] && !issueValid) begin
                issueValid = 1'b1;
                issueIdx = idx;
            end
        end

        // The head is the oldest load, so it always wins.
        // An MMIO head only goes once everything before it has committed
        if (entryValid[deqIndex] && (entryPending[deqIndex] || entryInOrderReady)) begin
            issueValid = 1'b1;
            issueIdx = deqIndex;
        end
    end

endmodule

/* loadBuffer.sv */
`timescale 1ns/10ps
`include "lsuOrder_params.svh"

module loadBuffer (
    input  logic                        clk,
    input  logic                        rst,
    input  memOpPkg::AguLoad            aguLoad,
    input  memOpPkg::AguStore           aguStore,
    input  memOpPkg::SqN                commitSqN,
    input  logic                        sqDone,
    input  recoveryPkg::Recovery        branchIn,
    input  logic [$clog2(`LB_SIZE)-1:0] issueIdx,
    input  logic                        issueValid,
    output recoveryPkg::Recovery        violation,
    output memOpPkg::LoadSqN            maxLoadSqN,
    output logic [`LB_SIZE-1:0]         entryValid,
    output logic [`LB_SIZE-1:0]         entryPending,
    output logic                        entryInOrderReady,
    output logic [$clog2(`LB_SIZE)-1:0] deqIndex,
    lateLoadIf.source                   lateLoad,
    ldAckIf.sink                        ldAck
);

    localparam int IdxWidth = $clog2(`LB_SIZE);
    localparam int HighWidth = $bits(memOpPkg::LoadSqN) - IdxWidth;
    localparam memOpPkg::LoadSqN LastOffset = memOpPkg::LoadSqN'(`LB_SIZE - 1);

    // The slot index supplies the low load sequence bits, only the rest is kept
    typedef struct packed {
        memOpPkg::SqN         sqN;
        memOpPkg::Tag         tagDst;
        logic [HighWidth-1:0] highLdSqN;
        memOpPkg::AccessSize  size;
        logic [31:0]          addr;
        logic                 signExtend;
        logic                 doNotCommit;
    } LbEntry;

    LbEntry entries [`LB_SIZE];
    logic [`LB_SIZE-1:0] validQ;
    logic [`LB_SIZE-1:0] issuedQ;
    logic [`LB_SIZE-1:0] nonSpecQ;
    memOpPkg::LoadSqN baseIndex;
    memOpPkg::MemLoad lateQ;

    logic nonSpec;
    logic delayLoad;
    logic insertLoad;
    logic insertStore;
    logic storeConflict;
    logic startLate;
    logic ackFail;
    logic [IdxWidth-1:0] insIdx;
    logic [IdxWidth-1:0] ackIdx;
    logic [`LB_SIZE-1:0] retireMask;
    logic [$clog2(`RETIRE_WIDTH):0] retireCount;

    assign deqIndex = baseIndex[IdxWidth-1:0];
    assign maxLoadSqN = baseIndex + LastOffset;
    assign insIdx = aguLoad.loadSqN[IdxWidth-1:0];
    assign ackIdx = ldAck.loadSqN[IdxWidth-1:0];
    assign ackFail = ldAck.valid && ldAck.fail;

    // Ops younger than a taken branch in the same cycle are dropped
    assign insertLoad = aguLoad.valid &&
        (!branchIn.taken || $signed(aguLoad.sqN - branchIn.sqN) <= 0);
    assign insertStore = aguStore.valid &&
        (!branchIn.taken || $signed(aguStore.sqN - branchIn.sqN) <= 0);

    // MMIO loads wait for the head, and a load hit by an older store in the
    // same cycle waits until that store is visible
    assign nonSpec = `IS_MMIO(aguLoad.addr);
    assign delayLoad = nonSpec || (aguStore.valid &&
        $signed(aguStore.loadSqN - aguLoad.loadSqN) <= 0 &&
        memOpPkg::bytesOverlap(aguLoad.addr, aguLoad.size, aguStore.addr, aguStore.size));

    assign lateLoad.directValid = insertLoad && !delayLoad;
    assign lateLoad.valid = lateQ.valid;
    assign lateLoad.load = lateQ;

    assign entryValid = validQ & ~issuedQ;
    assign entryPending = entryValid & ~nonSpecQ;
    assign entryInOrderReady = sqDone && (commitSqN == entries[deqIndex].sqN);

    assign startLate = !lateQ.valid && issueValid && !branchIn.taken;

    // Any younger load that already read memory has seen stale data
    always_comb begin
        storeConflict = 1'b0;
        for (int i = 0; i < `LB_SIZE; i++) begin
            if (validQ[i] && issuedQ[i] &&
                $signed(aguStore.loadSqN - {entries[i].highLdSqN, IdxWidth'(i)}) <= 0 &&
                memOpPkg::bytesOverlap(entries[i].addr, entries[i].size,
                                       aguStore.addr, aguStore.size)) begin
                storeConflict = 1'b1;
            end
        end
    end

    // Retire a contiguous run of committed loads from the head
    always_comb begin
        logic run;
        logic [IdxWidth-1:0] idx;
        run = !startLate && !branchIn.taken;
        retireMask = '0;
        retireCount = '0;
        for (int i = 0; i < `RETIRE_WIDTH; i++) begin
            idx = deqIndex + IdxWidth'(i);
            run = run && validQ[idx] && issuedQ[idx] &&
                $signed(commitSqN - entries[idx].sqN) > 0;
            if (run) begin
                retireMask[idx] = 1'b1;
                retireCount = retireCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
            baseIndex <= '0;
            lateQ.valid <= 1'b0;
            violation.taken <= 1'b0;
        end else begin
            violation.taken <= insertStore && storeConflict;
            // Recovery restarts right after the store, which covers the offending load
            violation.sqN <= aguStore.sqN;
            violation.loadSqN <= aguStore.loadSqN;
            violation.dstPc <= aguStore.pc + (aguStore.compressed ? 32'd2 : 32'd4);
            violation.flush <= 1'b0;

            if (lateQ.valid && lateLoad.accept) begin
                lateQ.valid <= 1'b0;
            end

            if (branchIn.taken) begin
                for (int i = 0; i < `LB_SIZE; i++) begin
                    if ($signed(entries[i].sqN - branchIn.sqN) > 0) begin
                        validQ[i] <= 1'b0;
                    end
                end
                if (branchIn.flush) begin
                    baseIndex <= branchIn.loadSqN;
                end
                if ($signed(lateQ.sqN - branchIn.sqN) > 0) begin
                    lateQ.valid <= 1'b0;
                end
            end else begin
                validQ <= validQ & ~retireMask;
                baseIndex <= baseIndex + memOpPkg::LoadSqN'(retireCount);
                if (startLate) begin
                    lateQ <= '{
                        valid:       1'b1,
                        addr:        entries[issueIdx].addr,
                        size:        entries[issueIdx].size,
                        signExtend:  entries[issueIdx].signExtend,
                        sqN:         entries[issueIdx].sqN,
                        loadSqN:     {entries[issueIdx].highLdSqN, issueIdx},
                        tagDst:      entries[issueIdx].tagDst,
                        doNotCommit: entries[issueIdx].doNotCommit,
                        isMmio:      nonSpecQ[issueIdx]
                    };
                end
            end

            if (insertLoad) begin
                validQ[insIdx] <= 1'b1;
            end
        end
    end

    // A nack lands after insertion so a displaced AGU load reissues late
    always_ff @(posedge clk) begin
        if (insertLoad) begin
            entries[insIdx] <= '{
                sqN:         aguLoad.sqN,
                tagDst:      aguLoad.tagDst,
                highLdSqN:   aguLoad.loadSqN[$bits(memOpPkg::LoadSqN)-1:IdxWidth],
                size:        aguLoad.size,
                addr:        aguLoad.addr,
                signExtend:  aguLoad.signExtend,
                doNotCommit: aguLoad.doNotCommit
            };
            issuedQ[insIdx] <= !delayLoad;
            nonSpecQ[insIdx] <= nonSpec;
        end
        if (startLate) begin
            issuedQ[issueIdx] <= 1'b1;
        end
        if (ackFail) begin
            issuedQ[ackIdx] <= 1'b0;
        end
    end

    // Rename never hands out a load sequence number past maxLoadSqN
    assert property (@(posedge clk) disable iff (rst) insertLoad |-> !validQ[insIdx])
        else $error("load inserted into occupied slot %0d", insIdx);

    // The core redirects on the first violation before more stores arrive
    assert property (@(posedge clk) disable iff (rst) violation.taken |=> !violation.taken)
        else $error("violation held for more than one cycle");

endmodule

/* loadPortArbiter.sv */
`timescale 1ns/10ps

module loadPortArbiter (
    input  logic              clk,
    input  logic              rst,
    input  memOpPkg::AguLoad  aguLoad,
    input  logic              memStall,
    input  logic              memNack,
    input  memOpPkg::LoadSqN  memNackSqN,
    output memOpPkg::MemLoad  memLoad,
    lateLoadIf.sink           lateLoad,
    ldAckIf.source            ldAck
);

    logic aguFail;
    logic nackHeld;
    memOpPkg::LoadSqN nackHeldSqN;

    // A late load is older than anything coming from the AGU, so it goes first
    assign lateLoad.accept = !memStall;
    assign aguFail = lateLoad.directValid && (memStall || lateLoad.valid);

    // Only one ack per cycle, so an external nack that meets a displaced
    // AGU load waits one cycle in nackHeld
    always_comb begin
        ldAck.valid = 1'b1;
        ldAck.fail = 1'b1;
        if (aguFail) begin
            ldAck.loadSqN = aguLoad.loadSqN;
        end else if (nackHeld) begin
            ldAck.loadSqN = nackHeldSqN;
        end else if (memNack) begin
            ldAck.loadSqN = memNackSqN;
        end else begin
            ldAck.valid = !memStall && (lateLoad.valid || lateLoad.directValid);
            ldAck.fail = 1'b0;
            ldAck.loadSqN = lateLoad.valid ? lateLoad.load.loadSqN : aguLoad.loadSqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nackHeld <= 1'b0;
        end else begin
            nackHeld <= (memNack && (aguFail || nackHeld)) || (nackHeld && aguFail);
        end
        if (memNack) begin
            nackHeldSqN <= memNackSqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memLoad.valid <= 1'b0;
        end else if (!memStall) begin
            if (lateLoad.valid) begin
                memLoad <= lateLoad.load;
            end else if (lateLoad.directValid) begin
                // Direct loads are never MMIO, the buffer always delays those
                memLoad <= '{
                    valid:       1'b1,
                    addr:        aguLoad.addr,
                    size:        aguLoad.size,
                    signExtend:  aguLoad.signExtend,
                    sqN:         aguLoad.sqN,
                    loadSqN:     aguLoad.loadSqN,
                    tagDst:      aguLoad.tagDst,
                    doNotCommit: aguLoad.doNotCommit,
                    isMmio:      1'b0
                };
            end else begin
                memLoad.valid <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) memStall |=> $stable(memLoad))
        else $error("memLoad changed while memory port stalled");

endmodule

/* loadStoreOrdering.sv */
`timescale 1ns/10ps
`include "lsuOrder_params.svh"

module loadStoreOrdering (
    input  logic                 clk,
    input  logic                 rst,
    input  memOpPkg::AguLoad     aguLoad,
    input  memOpPkg::AguStore    aguStore,
    input  memOpPkg::SqN         commitSqN,
    input  logic                 sqDone,
    input  recoveryPkg::Recovery branchIn,
    input  logic                 memStall,
    input  logic                 memNack,
    input  memOpPkg::LoadSqN     memNackSqN,
    output memOpPkg::MemLoad     memLoad,
    output recoveryPkg::Recovery violation,
    output memOpPkg::LoadSqN     maxLoadSqN
);

    lateLoadIf lateLoadBus ();
    ldAckIf ldAckBus ();

    logic [`LB_SIZE-1:0] entryValid;
    logic [`LB_SIZE-1:0] entryPending;
    logic entryInOrderReady;
    logic [$clog2(`LB_SIZE)-1:0] deqIndex;
    logic [$clog2(`LB_SIZE)-1:0] issueIdx;
    logic issueValid;

    loadBuffer buffer (
        .clk               (clk),
        .rst               (rst),
        .aguLoad           (aguLoad),
        .aguStore          (aguStore),
        .commitSqN         (commitSqN),
        .sqDone            (sqDone),
        .branchIn          (branchIn),
        .issueIdx          (issueIdx),
        .issueValid        (issueValid),
        .violation         (violation),
        .maxLoadSqN        (maxLoadSqN),
        .entryValid        (entryValid),
        .entryPending      (entryPending),
        .entryInOrderReady (entryInOrderReady),
        .deqIndex          (deqIndex),
        .lateLoad          (lateLoadBus.source),
        .ldAck             (ldAckBus.sink)
    );

    lateIssueSelect selector (
        .entryValid        (entryValid),
        .entryPending      (entryPending),
        .entryInOrderReady (entryInOrderReady),
        .deqIndex          (deqIndex),
        .issueIdx          (issueIdx),
        .issueValid        (issueValid)
    );

    loadPortArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .aguLoad    (aguLoad),
        .memStall   (memStall),
        .memNack    (memNack),
        .memNackSqN (memNackSqN),
        .memLoad    (memLoad),
        .lateLoad   (lateLoadBus.sink),
        .ldAck      (ldAckBus.source)
    );

endmodule

/* tbLoadStoreOrdering.sv */
`timescale 1ns/10ps
`include "lsuOrder_params.svh"

module tbLoadStoreOrdering;

    localparam int ClkPeriod = 4;
    localparam int ResetCycles = 8;
    localparam int MaxWait = 32;
    localparam int TestCount = 6;
    localparam int CyclesPerTest = 4 * MaxWait + 24;
    // Twice the worst case of all tests together
    localparam int WatchdogNs = 2 * ClkPeriod * (ResetCycles + TestCount * CyclesPerTest);

    logic clk;
    logic rst;
    memOpPkg::AguLoad aguLoad;
    memOpPkg::AguStore aguStore;
    memOpPkg::SqN commitSqN;
    logic sqDone;
    recoveryPkg::Recovery branchIn;
    logic memStall;
    logic memNack;
    memOpPkg::LoadSqN memNackSqN;
    memOpPkg::MemLoad memLoad;
    recoveryPkg::Recovery violation;
    memOpPkg::LoadSqN maxLoadSqN;

    int errors = 0;
    int testsFailed = 0;
    int seedDraw;
    memOpPkg::SqN nextSqN = '0;
    memOpPkg::LoadSqN nextLdSqN = '0;

    loadStoreOrdering dut (
        .clk        (clk),
        .rst        (rst),
        .aguLoad    (aguLoad),
        .aguStore   (aguStore),
        .commitSqN  (commitSqN),
        .sqDone     (sqDone),
        .branchIn   (branchIn),
        .memStall   (memStall),
        .memNack    (memNack),
        .memNackSqN (memNackSqN),
        .memLoad    (memLoad),
        .violation  (violation),
        .maxLoadSqN (maxLoadSqN)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the tests did not complete", WatchdogNs);
        $display("Finished with errors");
        $finish;
    end

    // Random word-aligned address well clear of the MMIO window
    function automatic logic [31:0] plainAddr();
        return 32'h1000_0000 | ($urandom & 32'h0fff_fffc);
    endfunction

    function automatic memOpPkg::AguLoad makeLoad(input logic [31:0] addr,
                                                  input memOpPkg::AccessSize size,
                                                  input memOpPkg::SqN sqN,
                                                  input memOpPkg::LoadSqN ldSqN);
        memOpPkg::AguLoad ld;
        ld.valid = 1'b1;
        ld.addr = addr;
        ld.size = size;
        ld.signExtend = 1'($urandom);
        ld.sqN = sqN;
        ld.loadSqN = ldSqN;
        ld.tagDst = memOpPkg::Tag'($urandom);
        ld.doNotCommit = 1'b0;
        return ld;
    endfunction

    function automatic memOpPkg::AguStore makeStore(input logic [31:0] addr,
                                                    input memOpPkg::AccessSize size,
                                                    input memOpPkg::SqN sqN,
                                                    input memOpPkg::LoadSqN ldSqN,
                                                    input logic compressed);
        memOpPkg::AguStore st;
        st.valid = 1'b1;
        st.addr = addr;
        st.size = size;
        st.pc = $urandom & 32'hffff_fffe;
        st.compressed = compressed;
        st.sqN = sqN;
        st.loadSqN = ldSqN;
        st.doNotCommit = 1'b0;
        return st;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        assert (cond) else begin
            $display("Failure at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic checkMemLoad(input memOpPkg::AguLoad ld, input logic mmio);
        compareValue("memLoad.valid", memLoad.valid, 1'b1);
        compareValue("memLoad.addr", memLoad.addr, ld.addr);
        compareValue("memLoad.size", memLoad.size, ld.size);
        compareValue("memLoad.signExtend", memLoad.signExtend, ld.signExtend);
        compareValue("memLoad.sqN", memLoad.sqN, ld.sqN);
        compareValue("memLoad.loadSqN", memLoad.loadSqN, ld.loadSqN);
        compareValue("memLoad.tagDst", memLoad.tagDst, ld.tagDst);
        compareValue("memLoad.doNotCommit", memLoad.doNotCommit, ld.doNotCommit);
        compareValue("memLoad.isMmio", memLoad.isMmio, mmio);
    endtask

    task automatic presentLoad(input memOpPkg::AguLoad ld);
        @(posedge clk);
        aguLoad <= ld;
        @(posedge clk);
        aguLoad.valid <= 1'b0;
    endtask

    // Store is shown for one cycle and the recovery pulse checked after it
    task automatic presentStore(input memOpPkg::AguStore st, input logic expectHit,
                                input logic [31:0] expectPc);
        @(posedge clk);
        aguStore <= st;
        @(posedge clk);
        aguStore.valid <= 1'b0;
        @(negedge clk);
        compareValue("violation.taken", violation.taken, expectHit);
        if (expectHit) begin
            compareValue("violation.sqN", violation.sqN, st.sqN);
            compareValue("violation.loadSqN", violation.loadSqN, st.loadSqN);
            compareValue("violation.dstPc", violation.dstPc, expectPc);
            compareValue("violation.flush", violation.flush, 1'b0);
        end
        @(negedge clk);
        compareValue("violation.taken", violation.taken, 1'b0);
    endtask

    task automatic awaitLoad(input memOpPkg::LoadSqN ldSqN, output logic found);
        found = 1'b0;
        for (int i = 0; i < MaxWait && !found; i++) begin
            @(negedge clk);
            found = memLoad.valid && (memLoad.loadSqN == ldSqN);
        end
        confirm(found, $sformatf("load %0d did not reach memLoad within %0d cycles",
                                 ldSqN, MaxWait));
    endtask

    task automatic watchQuiet(input int cycles, output logic seen);
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            seen = seen || memLoad.valid;
        end
    endtask

    // Commit everything handed out so far and wait for the buffer to drain
    task automatic commitAll();
        logic done;
        memOpPkg::LoadSqN expMax;
        expMax = memOpPkg::LoadSqN'(nextLdSqN + `LB_SIZE - 1);
        done = 1'b0;
        @(posedge clk);
        commitSqN <= nextSqN;
        for (int i = 0; i < MaxWait && !done; i++) begin
            @(negedge clk);
            done = (maxLoadSqN == expMax);
        end
        confirm(done, "committed loads did not all retire from the load buffer");
    endtask

    task automatic finishTest(input string name, input int startErrors);
        if (errors == startErrors) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - startErrors);
            testsFailed++;
        end
    endtask

    task automatic resetState();
        int startErrors;
        startErrors = errors;
        @(negedge clk);
        compareValue("memLoad.valid", memLoad.valid, 1'b0);
        compareValue("violation.taken", violation.taken, 1'b0);
        compareValue("maxLoadSqN", maxLoadSqN, `LB_SIZE - 1);
        finishTest("resetState", startErrors);
    endtask

    task automatic directLoad();
        memOpPkg::AguLoad ld;
        int startErrors;
        startErrors = errors;
        ld = makeLoad(plainAddr(), memOpPkg::SizeWord, nextSqN, nextLdSqN);
        nextSqN++;
        nextLdSqN++;
        presentLoad(ld);
        @(negedge clk);
        checkMemLoad(ld, 1'b0);
        commitAll();
        finishTest("directLoad", startErrors);
    endtask

    task automatic mmioInOrder();
        memOpPkg::AguLoad ld;
        logic seen;
        logic found;
        int startErrors;
        startErrors = errors;
        ld = makeLoad(`MMIO_BASE | ($urandom & 32'h00ff_fffc), memOpPkg::SizeWord,
                      nextSqN, nextLdSqN);
        nextSqN++;
        nextLdSqN++;
        // Store queue empty but an older instruction still uncommitted
        @(posedge clk);
        commitSqN <= ld.sqN - 1;
        sqDone <= 1'b1;
        presentLoad(ld);
        watchQuiet(12, seen);
        confirm(!seen, "MMIO load issued before commitSqN reached it");
        @(posedge clk);
        commitSqN <= ld.sqN;
        sqDone <= 1'b0;
        watchQuiet(12, seen);
        confirm(!seen, "MMIO load issued while the store queue was not drained");
        @(posedge clk);
        sqDone <= 1'b1;
        awaitLoad(ld.loadSqN, found);
        if (found) begin
            checkMemLoad(ld, 1'b1);
        end
        @(posedge clk);
        sqDone <= 1'b0;
        commitAll();
        finishTest("mmioInOrder", startErrors);
    endtask

    task automatic storeAfterLoad();
        memOpPkg::AguLoad ld;
        memOpPkg::AguStore st;
        memOpPkg::SqN firstSq;
        logic [31:0] addr;
        int startErrors;
        startErrors = errors;
        firstSq = nextSqN;
        addr = plainAddr();
        // Three stores precede the load in program order but execute after it
        ld = makeLoad(addr, memOpPkg::SizeByte, firstSq + 3, nextLdSqN);
        nextSqN += 4;
        nextLdSqN++;
        presentLoad(ld);
        st = makeStore(addr + 3, memOpPkg::SizeByte, firstSq, ld.loadSqN, 1'b1);
        presentStore(st, 1'b0, st.pc + 32'd2);
        st = makeStore(addr, memOpPkg::SizeHalf, firstSq + 1, ld.loadSqN, 1'b0);
        presentStore(st, 1'b1, st.pc + 32'd4);
        st = makeStore(addr, memOpPkg::SizeWord, firstSq + 2, ld.loadSqN, 1'b1);
        presentStore(st, 1'b1, st.pc + 32'd2);
        commitAll();
        finishTest("storeAfterLoad", startErrors);
    endtask

    task automatic sameCycleStore();
        memOpPkg::AguLoad ld;
        memOpPkg::AguStore st;
        logic [31:0] addr;
        logic found;
        int startErrors;
        startErrors = errors;
        addr = plainAddr();
        ld = makeLoad(addr, memOpPkg::SizeWord, nextSqN + 1, nextLdSqN);
        st = makeStore(addr + 2, memOpPkg::SizeHalf, nextSqN, ld.loadSqN, 1'b0);
        nextSqN += 2;
        nextLdSqN++;
        @(posedge clk);
        aguLoad <= ld;
        aguStore <= st;
        @(posedge clk);
        aguLoad.valid <= 1'b0;
        aguStore.valid <= 1'b0;
        @(negedge clk);
        compareValue("memLoad.valid", memLoad.valid, 1'b0);
        compareValue("violation.taken", violation.taken, 1'b0);
        awaitLoad(ld.loadSqN, found);
        if (found) begin
            checkMemLoad(ld, 1'b0);
        end
        // Memory rejects the load, so it goes round the late path again
        @(posedge clk);
        memNack <= 1'b1;
        memNackSqN <= ld.loadSqN;
        @(posedge clk);
        memNack <= 1'b0;
        awaitLoad(ld.loadSqN, found);
        if (found) begin
            checkMemLoad(ld, 1'b0);
        end
        commitAll();
        finishTest("sameCycleStore", startErrors);
    endtask

    task automatic retireAndFlush();
        memOpPkg::AguLoad ld;
        memOpPkg::AguStore st;
        memOpPkg::LoadSqN base;
        logic [31:0] addr;
        logic seen;
        int startErrors;
        startErrors = errors;
        base = nextLdSqN;
        for (int i = 0; i < 6; i++) begin
            ld = makeLoad(plainAddr(), memOpPkg::SizeWord, nextSqN, nextLdSqN);
            nextSqN++;
            nextLdSqN++;
            presentLoad(ld);
        end
        @(negedge clk);
        compareValue("maxLoadSqN", maxLoadSqN, memOpPkg::LoadSqN'(base + `LB_SIZE - 1));
        @(posedge clk);
        commitSqN <= nextSqN;
        // Six committed loads leave over two cycles
        @(posedge clk);
        @(negedge clk);
        compareValue("maxLoadSqN", maxLoadSqN,
                     memOpPkg::LoadSqN'(base + `RETIRE_WIDTH + `LB_SIZE - 1));
        @(negedge clk);
        compareValue("maxLoadSqN", maxLoadSqN, memOpPkg::LoadSqN'(base + 6 + `LB_SIZE - 1));

        addr = plainAddr();
        ld = makeLoad(addr, memOpPkg::SizeWord, nextSqN + 1, nextLdSqN);
        st = makeStore(addr, memOpPkg::SizeByte, nextSqN, ld.loadSqN, 1'b0);
        @(posedge clk);
        aguLoad <= ld;
        aguStore <= st;
        @(posedge clk);
        aguLoad.valid <= 1'b0;
        aguStore.valid <= 1'b0;
        // Mispredicted branch at the store squashes the delayed load behind it
        branchIn <= '{taken: 1'b1, sqN: st.sqN, loadSqN: ld.loadSqN, dstPc: 32'h0, flush: 1'b1};
        @(posedge clk);
        branchIn.taken <= 1'b0;
        branchIn.flush <= 1'b0;
        nextSqN += 2;
        watchQuiet(16, seen);
        confirm(!seen, "flushed delayed load still reached memLoad");
        compareValue("maxLoadSqN", maxLoadSqN,
                     memOpPkg::LoadSqN'(ld.loadSqN + `LB_SIZE - 1));
        finishTest("retireAndFlush", startErrors);
    endtask

    initial begin
        $timeformat(-9, 2, " ns", 0);
        // The first call seeds the generator for the whole run
        seedDraw = $urandom(32'hdc31_6894);
        rst = 1'b1;
        aguLoad = '0;
        aguStore = '0;
        commitSqN = '0;
        sqDone = 1'b0;
        branchIn = '0;
        memStall = 1'b0;
        memNack = 1'b0;
        memNackSqN = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        resetState();
        directLoad();
        mmioInOrder();
        storeAfterLoad();
        sameCycleStore();
        retireAndFlush();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 TestCount, testsFailed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* loadStoreOrdering.f */
+incdir+.
memOpPkg.sv
recoveryPkg.sv
lsuIfc.sv
lateIssueSelect.sv
loadBuffer.sv
loadPortArbiter.sv
loadStoreOrdering.sv
tbLoadStoreOrdering.sv
